// File: issue_stage.f
logic/issue_pkg.sv
logic/priority_select.sv
logic/operand_fetch.sv
logic/issue_select.sv
logic/issue_stage.sv
tb/issue_checker.sv
tb/issue_stage_tb.sv

// File: tb/issue_stimulus.txt
# test rs_valid src1_rdy src2_rdy mult_mask mult_free mult_cdb_req cdb_mask exp_issuing exp_gnt
# test is decimal, every other column is hex; one line per clock cycle
# test 1: idle after reset, nothing valid
1 00 00 00 00 1 0 3 00 0
1 00 ff ff 00 1 0 3 00 0
1 00 ff ff ff 1 0 3 00 0
# test 2: alu picks lowest index first, two per cycle, unready entries stay
2 ff ff ff 00 1 0 3 03 0
2 fc ff ff 00 1 0 3 0c 0
2 f0 a0 ff 00 1 0 3 a0 0
2 50 ff 10 00 1 0 3 10 0
2 40 00 ff 00 1 0 3 00 0
2 81 81 80 00 1 0 3 80 0
# test 3: multiplier completion takes a cdb slot, second alu pick waits
3 0f ff ff 00 1 1 3 01 1
3 0e ff ff 00 1 1 3 02 1
3 0c ff ff 00 1 0 3 0c 0
3 30 10 ff 00 1 1 3 10 1
3 00 ff ff 00 1 1 3 00 1
# test 4: busy multiplier holds its entries back
4 03 ff ff 03 0 0 3 00 0
4 03 ff ff 03 0 0 3 00 0
4 03 ff ff 03 1 0 3 01 0
4 02 ff ff 03 1 0 3 02 0
4 0f ff ff 05 1 1 3 03 1
4 0c ff ff 05 0 0 3 08 0
4 04 ff ff 05 1 0 3 04 0
# test 5: operands from regfile and cdb with fewer forwarding slots
5 ff ff ff 10 1 0 1 13 0
5 ec ff ff 10 1 0 0 0c 0
5 e0 ff ff 20 1 0 2 e0 0
5 03 ff ff 00 1 0 3 03 0

// File: tb/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

    import issue_pkg::*;

    localparam int CLOCK_PERIOD  = 20;
    localparam int RESET_CYCLES  = 4;
    localparam int MARGIN_CYCLES = 100;

    // one line of the stimulus file
    typedef struct packed {
        logic [7:0]           test;
        logic [RS_SZ-1:0]     rs_valid;
        logic [RS_SZ-1:0]     src1_rdy;
        logic [RS_SZ-1:0]     src2_rdy;
        logic [RS_SZ-1:0]     mult_mask;
        logic                 mult_free;
        logic                 mult_cdb_req;
        logic [CDB_WIDTH-1:0] cdb_mask;
        logic [RS_SZ-1:0]     exp_issuing;
        logic                 exp_gnt;
    } vector_t;

    logic                 clock;
    logic                 reset;
    rs_entry_t            rs_data [RS_SZ];
    logic [RS_SZ-1:0]     rs_valid;
    logic [NUM_PREGS-1:0] complete_list;
    cdb_packet_t          cdb [CDB_WIDTH];
    src_pair_t            alu_read_idx [NUM_ALU];
    operand_pair_t        alu_read_data [NUM_ALU];
    src_pair_t            mult_read_idx;
    operand_pair_t        mult_read_data;
    logic                 mult_free;
    logic                 mult_cdb_req;
    logic                 mult_cdb_gnt;
    logic [RS_SZ-1:0]     rs_issuing;
    alu_packet_t          alu_packets [NUM_ALU];
    mult_packet_t         mult_packet;

    // expectations handed to the checker
    logic                 vec_active;
    int                   test_id;
    logic [RS_SZ-1:0]     exp_issuing;
    logic                 exp_gnt;
    logic                 run_done;
    logic                 summary_done;
    int                   error_count;

    vector_t              vectors [$];
    int                   num_vectors;
    logic [15:0]          lfsr_state;
    // entries that left the rs get fresh tags on the next vector
    logic [RS_SZ-1:0]     refresh;

    issue_stage u_dut (
        .clock          (clock),
        .reset          (reset),
        .rs_data        (rs_data),
        .rs_valid       (rs_valid),
        .complete_list  (complete_list),
        .cdb            (cdb),
        .alu_read_idx   (alu_read_idx),
        .alu_read_data  (alu_read_data),
        .mult_read_idx  (mult_read_idx),
        .mult_read_data (mult_read_data),
        .mult_free      (mult_free),
        .mult_cdb_req   (mult_cdb_req),
        .mult_cdb_gnt   (mult_cdb_gnt),
        .rs_issuing     (rs_issuing),
        .alu_packets    (alu_packets),
        .mult_packet    (mult_packet)
    );

    issue_checker u_checker (
        .clock         (clock),
        .reset         (reset),
        .rs_data       (rs_data),
        .rs_issuing    (rs_issuing),
        .mult_cdb_gnt  (mult_cdb_gnt),
        .alu_read_idx  (alu_read_idx),
        .mult_read_idx (mult_read_idx),
        .alu_packets   (alu_packets),
        .mult_packet   (mult_packet),
        .vec_active    (vec_active),
        .test_id       (test_id),
        .exp_issuing   (exp_issuing),
        .exp_gnt       (exp_gnt),
        .run_done      (run_done),
        .summary_done  (summary_done),
        .error_count   (error_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // regfile model, same-cycle read of tag plus 0x1000
    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_read_data[k].opa = 32'h1000 + alu_read_idx[k].src1;
            alu_read_data[k].opb = 32'h1000 + alu_read_idx[k].src2;
        end
        mult_read_data.opa = 32'h1000 + mult_read_idx.src1;
        mult_read_data.opb = 32'h1000 + mult_read_idx.src2;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    // odd tag goes onto a free enabled cdb slot, else it is made complete
    task automatic route_tag(input preg_idx_t tag_in, input logic [CDB_WIDTH-1:0] slot_mask,
                             output preg_idx_t tag_out);
        logic placed;
        tag_out = tag_in;
        placed  = 1'b0;
        if (tag_in[0]) begin
            for (int j = 0; j < CDB_WIDTH; j++) begin
                if (cdb[j].valid && cdb[j].tag == tag_in) begin
                    placed = 1'b1;
                end
            end
            for (int j = 0; j < CDB_WIDTH; j++) begin
                if (!placed && !cdb[j].valid && slot_mask[j]) begin
                    cdb[j].valid  = 1'b1;
                    cdb[j].tag    = tag_in;
                    cdb[j].result = 32'h2000 + tag_in;
                    placed        = 1'b1;
                end
            end
            if (!placed) begin
                tag_out = {tag_in[PREG_IDX_WIDTH-1:1], 1'b0};
            end
        end
    endtask

    task automatic apply_vector(input vector_t v);
        rs_entry_t  e;
        logic [7:0] bits;
        preg_idx_t  tag;
        for (int i = 0; i < RS_SZ; i++) begin
            e = rs_data[i];
            if (refresh[i]) begin
                take_bits(PREG_IDX_WIDTH, bits);
                e.srcs.src1 = bits[PREG_IDX_WIDTH-1:0];
                take_bits(PREG_IDX_WIDTH, bits);
                e.srcs.src2 = bits[PREG_IDX_WIDTH-1:0];
                take_bits(FUNC_WIDTH, bits);
                e.func = bits[FUNC_WIDTH-1:0];
                take_bits(PREG_IDX_WIDTH, bits);
                e.dest = bits[PREG_IDX_WIDTH-1:0];
            end
            e.fu_type    = v.mult_mask[i] ? FU_MULT : FU_ALU;
            e.src1_ready = v.src1_rdy[i];
            e.src2_ready = v.src2_rdy[i];
            rs_data[i]   = e;
        end
        for (int j = 0; j < CDB_WIDTH; j++) begin
            cdb[j] = '0;
        end
        // issuing entries need every odd source on the cdb this cycle
        for (int i = 0; i < RS_SZ; i++) begin
            if (v.exp_issuing[i]) begin
                e = rs_data[i];
                route_tag(e.srcs.src1, v.cdb_mask, tag);
                e.srcs.src1 = tag;
                route_tag(e.srcs.src2, v.cdb_mask, tag);
                e.srcs.src2 = tag;
                rs_data[i]  = e;
            end
        end
        rs_valid     = v.rs_valid;
        mult_free    = v.mult_free;
        mult_cdb_req = v.mult_cdb_req;
        test_id      = int'(v.test);
        exp_issuing  = v.exp_issuing;
        exp_gnt      = v.exp_gnt;
        vec_active   = 1'b1;
        refresh      = v.exp_issuing;
    endtask

    task automatic load_vectors(output int count);
        int         fd;
        string      line;
        int         test_num;
        logic [7:0] col [9];
        int         n;
        vector_t    v;
        count = 0;
        fd = $fopen("tb/issue_stimulus.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // lines starting with # describe the columns
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", test_num, col[0],
                                col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8]);
                    if (n == 10) begin
                        v.test         = test_num[7:0];
                        v.rs_valid     = col[0];
                        v.src1_rdy     = col[1];
                        v.src2_rdy     = col[2];
                        v.mult_mask    = col[3];
                        v.mult_free    = col[4][0];
                        v.mult_cdb_req = col[5][0];
                        v.cdb_mask     = col[6][CDB_WIDTH-1:0];
                        v.exp_issuing  = col[7];
                        v.exp_gnt      = col[8][0];
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
        count = vectors.size();
    endtask

    initial begin
        reset         = 1'b1;
        rs_valid      = '0;
        complete_list = 32'h5555_5555;
        mult_free     = 1'b0;
        mult_cdb_req  = 1'b0;
        vec_active    = 1'b0;
        test_id       = 0;
        exp_issuing   = '0;
        exp_gnt       = 1'b0;
        run_done      = 1'b0;
        lfsr_state    = 16'd88;
        refresh       = '1;
        for (int i = 0; i < RS_SZ; i++) begin
            rs_data[i] = '0;
        end
        for (int j = 0; j < CDB_WIDTH; j++) begin
            cdb[j] = '0;
        end
        load_vectors(num_vectors);
        if (num_vectors == 0) begin
            $display("no vectors could be read from tb/issue_stimulus.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            foreach (vectors[n]) begin
                apply_vector(vectors[n]);
                @(negedge clock);
            end
            // one idle cycle lets the last packets reach the checker
            vec_active   = 1'b0;
            rs_valid     = '0;
            mult_cdb_req = 1'b0;
            for (int j = 0; j < CDB_WIDTH; j++) begin
                cdb[j] = '0;
            end
            @(negedge clock);
            run_done = 1'b1;
            wait (summary_done);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog sized from the vector count
    initial begin
        wait (num_vectors > 0);
        #((num_vectors + MARGIN_CYCLES) * CLOCK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles",
                 num_vectors + MARGIN_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: tb/issue_checker.sv
`timescale 1ns/1ps

module issue_checker (
    input  logic                           clock,
    input  logic                           reset,
    input  issue_pkg::rs_entry_t           rs_data [issue_pkg::RS_SZ],
    input  logic [issue_pkg::RS_SZ-1:0]    rs_issuing,
    input  logic                           mult_cdb_gnt,
    input  issue_pkg::src_pair_t           alu_read_idx [issue_pkg::NUM_ALU],
    input  issue_pkg::src_pair_t           mult_read_idx,
    input  issue_pkg::alu_packet_t         alu_packets [issue_pkg::NUM_ALU],
    input  issue_pkg::mult_packet_t        mult_packet,
    input  logic                           vec_active,
    input  int                             test_id,
    input  logic [issue_pkg::RS_SZ-1:0]    exp_issuing,
    input  logic                           exp_gnt,
    input  logic                           run_done,
    output logic                           summary_done,
    output int                             error_count
);

    import issue_pkg::*;

    int        cur_test;
    int        test_checks;
    int        test_errors;
    int        total_checks;
    int        tests_run;
    int        tests_failed;
    // entries issued at the previous rising edge, -1 for an idle slot
    rs_entry_t prev_data [RS_SZ];
    int        prev_alu_idx [NUM_ALU];
    int        prev_mult_idx;

    // even tags sit in the regfile, odd tags arrive on the cdb
    function automatic data_t operand_for(input preg_idx_t tag);
        if (tag[0]) begin
            return 32'h2000 + tag;
        end
        return 32'h1000 + tag;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] expected);
        test_checks++;
        total_checks++;
        if (got !== expected) begin
            test_errors++;
            error_count++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h (test %0d, %0t)",
                     name, got, expected, cur_test, $time);
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d passed, %0d checks", cur_test, test_checks);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d of %0d checks wrong",
                     cur_test, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // packets now visible belong to the picks of the previous cycle
    task automatic check_packets();
        rs_entry_t e;
        for (int k = 0; k < NUM_ALU; k++) begin
            if (prev_alu_idx[k] >= 0) begin
                e = prev_data[prev_alu_idx[k]];
                compare_value($sformatf("alu_packets[%0d].valid", k), alu_packets[k].valid, 1);
                compare_value($sformatf("alu_packets[%0d].ctrl", k), alu_packets[k].ctrl,
                              {e.func, e.dest});
                compare_value($sformatf("alu_packets[%0d].operands", k),
                              alu_packets[k].operands,
                              {operand_for(e.srcs.src1), operand_for(e.srcs.src2)});
            end else begin
                compare_value($sformatf("alu_packets[%0d].valid", k), alu_packets[k].valid, 0);
            end
        end
        if (prev_mult_idx >= 0) begin
            e = prev_data[prev_mult_idx];
            compare_value("mult_packet.valid", mult_packet.valid, 1);
            compare_value("mult_packet.ctrl", mult_packet.ctrl, {e.func, e.dest});
            compare_value("mult_packet.operands", mult_packet.operands,
                          {operand_for(e.srcs.src1), operand_for(e.srcs.src2)});
        end else begin
            compare_value("mult_packet.valid", mult_packet.valid, 0);
        end
    endtask

    // alu slot k carries the k-th lowest issuing alu entry
    task automatic check_select();
        int n_alu;
        n_alu = 0;
        prev_mult_idx = -1;
        for (int k = 0; k < NUM_ALU; k++) begin
            prev_alu_idx[k] = -1;
        end
        for (int i = 0; i < RS_SZ; i++) begin
            if (exp_issuing[i] && rs_data[i].fu_type == FU_MULT) begin
                prev_mult_idx = i;
            end else if (exp_issuing[i] && n_alu < NUM_ALU) begin
                prev_alu_idx[n_alu] = i;
                n_alu++;
            end
        end
        compare_value("rs_issuing", rs_issuing, exp_issuing);
        compare_value("mult_cdb_gnt", mult_cdb_gnt, exp_gnt);
        for (int k = 0; k < NUM_ALU; k++) begin
            compare_value($sformatf("alu_read_idx[%0d]", k), alu_read_idx[k],
                          (prev_alu_idx[k] >= 0) ? rs_data[prev_alu_idx[k]].srcs : '0);
        end
        compare_value("mult_read_idx", mult_read_idx,
                      (prev_mult_idx >= 0) ? rs_data[prev_mult_idx].srcs : '0);
        prev_data = rs_data;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            prev_mult_idx = -1;
            for (int k = 0; k < NUM_ALU; k++) begin
                prev_alu_idx[k] = -1;
            end
        end else begin
            check_packets();
            if (vec_active) begin
                // a new test number closes the previous test
                if (test_id != cur_test) begin
                    if (cur_test != 0) begin
                        close_test();
                    end
                    cur_test = test_id;
                end
                check_select();
            end else begin
                prev_mult_idx = -1;
                for (int k = 0; k < NUM_ALU; k++) begin
                    prev_alu_idx[k] = -1;
                end
            end
        end
    end

    initial begin
        summary_done  = 1'b0;
        error_count   = 0;
        cur_test      = 0;
        test_checks   = 0;
        test_errors   = 0;
        total_checks  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        prev_mult_idx = -1;
        for (int k = 0; k < NUM_ALU; k++) begin
            prev_alu_idx[k] = -1;
        end
        wait (run_done);
        if (cur_test != 0) begin
            close_test();
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, error_count);
        summary_done = 1'b1;
    end

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                            clock,
    input  logic                            reset,
    input  issue_pkg::rs_entry_t            rs_data [issue_pkg::RS_SZ],
    input  logic [issue_pkg::RS_SZ-1:0]     rs_valid,
    input  logic [issue_pkg::NUM_PREGS-1:0] complete_list,
    input  issue_pkg::cdb_packet_t          cdb [issue_pkg::CDB_WIDTH],
    output issue_pkg::src_pair_t            alu_read_idx [issue_pkg::NUM_ALU],
    input  issue_pkg::operand_pair_t        alu_read_data [issue_pkg::NUM_ALU],
    output issue_pkg::src_pair_t            mult_read_idx,
    input  issue_pkg::operand_pair_t        mult_read_data,
    input  logic                            mult_free,
    input  logic                            mult_cdb_req,
    output logic                            mult_cdb_gnt,
    output logic [issue_pkg::RS_SZ-1:0]     rs_issuing,
    output issue_pkg::alu_packet_t          alu_packets [issue_pkg::NUM_ALU],
    output issue_pkg::mult_packet_t         mult_packet
);

    import issue_pkg::*;

    issue_slot_t   alu_picks [NUM_ALU];
    issue_slot_t   mult_pick;

    // ctrl fields going into the slots
    alu_ctrl_t     alu_ctrl [NUM_ALU];
    mult_ctrl_t    mult_ctrl;

    // registered slot outputs
    logic          alu_valid [NUM_ALU];
    alu_ctrl_t     alu_ctrl_q [NUM_ALU];
    operand_pair_t alu_operands [NUM_ALU];
    logic          mult_valid;
    mult_ctrl_t    mult_ctrl_q;
    operand_pair_t mult_operands;

    issue_select u_select (
        .clock        (clock),
        .reset        (reset),
        .rs_data      (rs_data),
        .rs_valid     (rs_valid),
        .mult_free    (mult_free),
        .mult_cdb_req (mult_cdb_req),
        .alu_picks    (alu_picks),
        .mult_pick    (mult_pick),
        .mult_cdb_gnt (mult_cdb_gnt),
        .rs_issuing   (rs_issuing)
    );

    // one fetch slot per alu
    for (genvar k = 0; k < NUM_ALU; k++) begin : g_alu_slot
        assign alu_ctrl[k].alu_func = alu_picks[k].entry.func;
        assign alu_ctrl[k].dest     = alu_picks[k].entry.dest;

        operand_fetch #(
            .ctrl_t (alu_ctrl_t)
        ) u_alu_fetch (
            .clock         (clock),
            .reset         (reset),
            .pick          (alu_picks[k]),
            .ctrl          (alu_ctrl[k]),
            .complete_list (complete_list),
            .cdb           (cdb),
            .read_idx      (alu_read_idx[k]),
            .read_data     (alu_read_data[k]),
            .valid         (alu_valid[k]),
            .ctrl_out      (alu_ctrl_q[k]),
            .operands      (alu_operands[k])
        );

        assign alu_packets[k] = '{valid: alu_valid[k], ctrl: alu_ctrl_q[k],
                                  operands: alu_operands[k]};
    end

    assign mult_ctrl.mult_func = mult_pick.entry.func;
    assign mult_ctrl.dest      = mult_pick.entry.dest;

    operand_fetch #(
        .ctrl_t (mult_ctrl_t)
    ) u_mult_fetch (
        .clock         (clock),
        .reset         (reset),
        .pick          (mult_pick),
        .ctrl          (mult_ctrl),
        .complete_list (complete_list),
        .cdb           (cdb),
        .read_idx      (mult_read_idx),
        .read_data     (mult_read_data),
        .valid         (mult_valid),
        .ctrl_out      (mult_ctrl_q),
        .operands      (mult_operands)
    );

    assign mult_packet = '{valid: mult_valid, ctrl: mult_ctrl_q, operands: mult_operands};

endmodule

// File: logic/issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  logic                         clock,
    input  logic                         reset,
    input  issue_pkg::rs_entry_t         rs_data [issue_pkg::RS_SZ],
    input  logic [issue_pkg::RS_SZ-1:0]  rs_valid,
    input  logic                         mult_free,
    input  logic                         mult_cdb_req,
    output issue_pkg::issue_slot_t       alu_picks [issue_pkg::NUM_ALU],
    output issue_pkg::issue_slot_t       mult_pick,
    output logic                         mult_cdb_gnt,
    output logic [issue_pkg::RS_SZ-1:0]  rs_issuing
);

    import issue_pkg::*;

    // ready entries split by unit class
    logic [RS_SZ-1:0]         alu_cand;
    logic [RS_SZ-1:0]         mult_cand;
    logic [RS_SZ-1:0]         mult_req;

    logic [RS_SZ-1:0]         alu_gnt_bus [NUM_ALU];
    logic [RS_SZ-1:0]         mult_gnt_bus [NUM_MULT];

    // cdb arbitration, bit 0 is the multiplier
    logic [NUM_ALU-1:0]       alu_has_pick;
    logic [CDB_ARB_WIDTH-1:0] cdb_req;
    logic [CDB_ARB_WIDTH-1:0] cdb_gnt_bus [CDB_WIDTH];
    logic [CDB_ARB_WIDTH-1:0] cdb_gnt;
    logic [NUM_ALU-1:0]       alu_slot_ok;

    always_comb begin
        for (int i = 0; i < RS_SZ; i++) begin
            alu_cand[i]  = rs_valid[i] && rs_data[i].src1_ready && rs_data[i].src2_ready
                           && (rs_data[i].fu_type == FU_ALU);
            mult_cand[i] = rs_valid[i] && rs_data[i].src1_ready && rs_data[i].src2_ready
                           && (rs_data[i].fu_type == FU_MULT);
        end
    end

    // busy multiplier blocks mult picks, entries stay in the rs
    assign mult_req = mult_free ? mult_cand : '0;

    priority_select #(
        .WIDTH  (RS_SZ),
        .GRANTS (NUM_ALU)
    ) u_alu_select (
        .req     (alu_cand),
        .gnt_bus (alu_gnt_bus)
    );

    priority_select #(
        .WIDTH  (RS_SZ),
        .GRANTS (NUM_MULT)
    ) u_mult_select (
        .req     (mult_req),
        .gnt_bus (mult_gnt_bus)
    );

    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_has_pick[k] = |alu_gnt_bus[k];
        end
    end

    // mult completion wins first slot, then alu picks in order
    assign cdb_req = {alu_has_pick, mult_cdb_req};

    priority_select #(
        .WIDTH  (CDB_ARB_WIDTH),
        .GRANTS (CDB_WIDTH)
    ) u_cdb_select (
        .req     (cdb_req),
        .gnt_bus (cdb_gnt_bus)
    );

    always_comb begin
        cdb_gnt = '0;
        for (int s = 0; s < CDB_WIDTH; s++) begin
            cdb_gnt = cdb_gnt | cdb_gnt_bus[s];
        end
    end

    assign mult_cdb_gnt = cdb_gnt[0];
    assign alu_slot_ok  = cdb_gnt[CDB_ARB_WIDTH-1:1];

    // one-hot grant to entry mux, alu picks need their cdb slot
    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_picks[k].valid = alu_has_pick[k] && alu_slot_ok[k];
            alu_picks[k].entry = '0;
            for (int i = 0; i < RS_SZ; i++) begin
                if (alu_gnt_bus[k][i]) begin
                    alu_picks[k].entry = rs_data[i];
                end
            end
        end
    end

    // multiplier writes back later through its own cdb request
    always_comb begin
        mult_pick.valid = |mult_gnt_bus[0];
        mult_pick.entry = '0;
        for (int i = 0; i < RS_SZ; i++) begin
            if (mult_gnt_bus[0][i]) begin
                mult_pick.entry = rs_data[i];
            end
        end
    end

    // tell the rs which entries leave this cycle
    always_comb begin
        rs_issuing = mult_gnt_bus[0];
        for (int k = 0; k < NUM_ALU; k++) begin
            if (alu_picks[k].valid) begin
                rs_issuing = rs_issuing | alu_gnt_bus[k];
            end
        end
    end

    a_issue_in_valid: assert property (@(posedge clock) disable iff (reset)
        (rs_issuing & ~rs_valid) == '0)
        else $error("issue_select: issuing an invalid rs entry");

    a_issue_count: assert property (@(posedge clock) disable iff (reset)
        $countones(rs_issuing) <= NUM_ALU + NUM_MULT)
        else $error("issue_select: more entries issued than units");

    a_gnt_needs_req: assert property (@(posedge clock) disable iff (reset)
        mult_cdb_gnt |-> mult_cdb_req)
        else $error("issue_select: cdb slot granted without a request");

endmodule

// File: logic/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch #(
    parameter type ctrl_t = issue_pkg::alu_ctrl_t
) (
    input  logic                          clock,
    input  logic                          reset,
    input  issue_pkg::issue_slot_t        pick,
    input  ctrl_t                         ctrl,
    input  logic [issue_pkg::NUM_PREGS-1:0] complete_list,
    input  issue_pkg::cdb_packet_t        cdb [issue_pkg::CDB_WIDTH],
    output issue_pkg::src_pair_t          read_idx,
    input  issue_pkg::operand_pair_t      read_data,
    output logic                          valid,
    output ctrl_t                         ctrl_out,
    output issue_pkg::operand_pair_t      operands
);

    import issue_pkg::*;

    // values seen on the cdb for each source
    data_t         fwd_opa;
    data_t         fwd_opb;
    logic          hit_src1;
    logic          hit_src2;
    operand_pair_t next_operands;

    // idle slot parks the read port at tag zero
    assign read_idx = pick.valid ? pick.entry.srcs : '0;

    // cam the cdb against both source tags
    always_comb begin
        fwd_opa  = '0;
        fwd_opb  = '0;
        hit_src1 = 1'b0;
        hit_src2 = 1'b0;
        for (int j = 0; j < CDB_WIDTH; j++) begin
            if (cdb[j].valid && (cdb[j].tag == pick.entry.srcs.src1)) begin
                fwd_opa  = cdb[j].result;
                hit_src1 = 1'b1;
            end
            if (cdb[j].valid && (cdb[j].tag == pick.entry.srcs.src2)) begin
                fwd_opb  = cdb[j].result;
                hit_src2 = 1'b1;
            end
        end
    end

    // complete tag reads the regfile, otherwise the value is still on the cdb
    always_comb begin
        next_operands.opa = complete_list[pick.entry.srcs.src1] ? read_data.opa : fwd_opa;
        next_operands.opb = complete_list[pick.entry.srcs.src2] ? read_data.opb : fwd_opb;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= pick.valid;
        end
    end

    // payload only loads on a real issue
    always_ff @(posedge clock) begin
        if (pick.valid) begin
            ctrl_out <= ctrl;
            operands <= next_operands;
        end
    end

    // rs woke the source up, so the producer must be completing this cycle
    a_src1_forwarded: assert property (@(posedge clock) disable iff (reset)
        (pick.valid && !complete_list[pick.entry.srcs.src1]) |-> hit_src1)
        else $error("operand_fetch: src1 neither complete nor on the cdb");

    a_src2_forwarded: assert property (@(posedge clock) disable iff (reset)
        (pick.valid && !complete_list[pick.entry.srcs.src2]) |-> hit_src2)
        else $error("operand_fetch: src2 neither complete nor on the cdb");

endmodule

// File: logic/priority_select.sv
`timescale 1ns/1ps

module priority_select #(
    parameter int WIDTH  = 8,
    parameter int GRANTS = 2
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt_bus [GRANTS]
);

    // requests not yet taken by an earlier grant
    logic [WIDTH-1:0] remaining;
    // bits already granted, for the overlap check
    logic [WIDTH-1:0] claimed;
    logic             overlap;

    // grant k takes the lowest bit still left after grants 0..k-1
    always_comb begin
        remaining = req;
        for (int k = 0; k < GRANTS; k++) begin
            // two's complement trick isolates the lowest set bit
            gnt_bus[k] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[k];
        end
    end

    // grants must stay disjoint or two units would take one entry
    always_comb begin
        claimed = '0;
        overlap = 1'b0;
        for (int k = 0; k < GRANTS; k++) begin
            overlap = overlap | (|(claimed & gnt_bus[k]));
            claimed = claimed | gnt_bus[k];
        end
        assert final (!overlap)
            else $error("priority_select: two grants share a request bit");
    end

endmodule

// File: logic/issue_pkg.sv
package issue_pkg;

    // reservation station and unit counts
    localparam int RS_SZ     = 8;
    localparam int NUM_ALU   = 2;
    localparam int NUM_MULT  = 1;
    // completion bus slots per cycle
    localparam int CDB_WIDTH = 2;

    // cdb arbiter inputs: mult request at bit 0, then one per alu pick
    localparam int CDB_ARB_WIDTH = NUM_ALU + 1;

    localparam int NUM_PREGS      = 32;
    localparam int PREG_IDX_WIDTH = $clog2(NUM_PREGS);
    localparam int DATA_WIDTH     = 32;
    localparam int FUNC_WIDTH     = 4;

    typedef logic [PREG_IDX_WIDTH-1:0] preg_idx_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;

    // unit class of an rs entry
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    // both source tags, also the register file read address of a slot
    typedef struct packed {
        preg_idx_t src1;
        preg_idx_t src2;
    } src_pair_t;

    // opa pairs with src1, opb with src2
    typedef struct packed {
        data_t opa;
        data_t opb;
    } operand_pair_t;

    typedef struct packed {
        logic [FUNC_WIDTH-1:0] alu_func;
        preg_idx_t             dest;
    } alu_ctrl_t;

    typedef struct packed {
        logic [FUNC_WIDTH-1:0] mult_func;
        preg_idx_t             dest;
    } mult_ctrl_t;

    // one rs entry as seen by issue
    typedef struct packed {
        fu_type_e              fu_type;
        src_pair_t             srcs;
        logic                  src1_ready;
        logic                  src2_ready;
        logic [FUNC_WIDTH-1:0] func;
        preg_idx_t             dest;
    } rs_entry_t;

    // entry chosen by select for one fetch slot
    typedef struct packed {
        logic      valid;
        rs_entry_t entry;
    } issue_slot_t;

    typedef struct packed {
        logic      valid;
        preg_idx_t tag;
        data_t     result;
    } cdb_packet_t;

    typedef struct packed {
        logic          valid;
        alu_ctrl_t     ctrl;
        operand_pair_t operands;
    } alu_packet_t;

    typedef struct packed {
        logic          valid;
        mult_ctrl_t    ctrl;
        operand_pair_t operands;
    } mult_packet_t;

endpackage
